// File: bench/clock_gen.sv
////////////////////
// Testbench clock and reset
////////////////////
`timescale 1ns/10ps

module clock_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held for three cycles
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: bench/operand_core_tb.sv
////////////////////
// Operand core testbench
// Random instruction stream against an
// architectural model, checked at retire
////////////////////
`timescale 1ns/10ps
`include "core_consts.svh"

module operand_core_tb;

    localparam int NUM_INSTR     = 400;
    localparam int CYCLE_LIMIT   = NUM_INSTR * 12 + 200;
    localparam int DRAIN_CYCLES  = 20;
    // Longest latency, accept to writeback of a multiply
    localparam int SETTLE_CYCLES = `CORE_MUL_STAGES + 1;

    // Instruction kinds in the stream
    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_XOR  = 2;
    localparam int K_MUL  = 3;
    localparam int K_ADDI = 4;
    localparam int K_XORI = 5;

    // Expected retirement of one instruction
    typedef struct packed {
        logic [4:0]            rd;
        logic [`CORE_XLEN-1:0] data;
        int                    seq;
    } expect_t;

    logic                  clk;
    logic                  rst_n;
    logic                  instr_valid;
    logic [31:0]           instr;
    logic                  stall;
    logic                  retire_valid;
    logic [4:0]            retire_rd;
    pipe_pkg::id_t         retire_id;
    logic [`CORE_XLEN-1:0] retire_data;

    // Model state
    logic [`CORE_XLEN-1:0] arch [32];
    expect_t               exp_q [`CORE_ID_COUNT][$];
    int                    issue_seq [32];
    int                    retire_seq [32];
    pipe_pkg::id_t         model_id;
    int                    accepted;
    int                    expected_retires;
    int                    retired;
    int                    cycles = 0;

    // Instruction at the DUT input
    int                    cur_kind;
    logic [4:0]            cur_rd;
    logic [4:0]            cur_rs1;
    logic [4:0]            cur_rs2;
    logic [11:0]           cur_imm;

    clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    operand_core dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .stall        (stall),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_id    (retire_id),
        .retire_data  (retire_data)
    );

    ////////////////////
    // Error handling
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_data(input pipe_pkg::id_t id,
                                input logic [`CORE_XLEN-1:0] got,
                                input logic [`CORE_XLEN-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: id %0d retired data %h, expected %h",
                               $time, id, got, exp));
        end
    endtask

    task automatic compare_rd(input pipe_pkg::id_t id,
                              input logic [4:0] got,
                              input logic [4:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: id %0d retired to x%0d, expected x%0d",
                               $time, id, got, exp));
        end
    endtask

    ////////////////////
    // Encoding and reference model
    function automatic logic [31:0] encode(input int kind, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [11:0] imm);
        logic [31:0] w;
        case (kind)
            K_ADD:   w = {7'b0000000, rs2, rs1, 3'b000, rd, isa_pkg::OPC_REG};
            K_SUB:   w = {7'b0100000, rs2, rs1, 3'b000, rd, isa_pkg::OPC_REG};
            K_XOR:   w = {7'b0000000, rs2, rs1, 3'b100, rd, isa_pkg::OPC_REG};
            K_MUL:   w = {7'b0000001, rs2, rs1, 3'b000, rd, isa_pkg::OPC_REG};
            K_ADDI:  w = {imm, rs1, 3'b000, rd, isa_pkg::OPC_IMM};
            default: w = {imm, rs1, 3'b100, rd, isa_pkg::OPC_IMM};
        endcase
        return w;
    endfunction

    // Immediates are sign extended from bit 11
    function automatic logic [`CORE_XLEN-1:0] sext12(input logic [11:0] imm);
        return {{(`CORE_XLEN-12){imm[11]}}, imm};
    endfunction

    function automatic logic [`CORE_XLEN-1:0] model_result(input int kind,
                                                           input logic [`CORE_XLEN-1:0] a,
                                                           input logic [`CORE_XLEN-1:0] b);
        logic [`CORE_XLEN-1:0] r;
        case (kind)
            K_SUB:          r = a - b;
            K_XOR, K_XORI:  r = a ^ b;
            // low half of the product
            K_MUL:          r = a * b;
            default:        r = a + b;
        endcase
        return r;
    endfunction

    task automatic pick_instr();
        cur_kind = int'($urandom_range(5, 0));
        // Small register subset so hazards are frequent
        cur_rd   = 5'($urandom_range(7, 0));
        cur_rs1  = 5'($urandom_range(7, 0));
        cur_rs2  = 5'($urandom_range(7, 0));
        cur_imm  = 12'($urandom);
    endtask

    // Program order update at acceptance
    task automatic accept_current();
        logic [`CORE_XLEN-1:0] a;
        logic [`CORE_XLEN-1:0] b;
        logic [`CORE_XLEN-1:0] res;
        expect_t               e;
        a = arch[cur_rs1];
        if (cur_kind == K_ADDI || cur_kind == K_XORI) begin
            b = sext12(cur_imm);
        end else begin
            b = arch[cur_rs2];
        end
        res = model_result(cur_kind, a, b);
        // x0 stays zero and never retires
        if (cur_rd != 5'd0) begin
            arch[cur_rd] = res;
            e.rd   = cur_rd;
            e.data = res;
            e.seq  = issue_seq[cur_rd];
            issue_seq[cur_rd]++;
            exp_q[model_id].push_back(e);
            expected_retires++;
        end
        // Ids go round robin, x0 writes included
        model_id = model_id + pipe_pkg::id_t'(1);
        accepted++;
    endtask

    ////////////////////
    // Retire check
    task automatic check_retire();
        expect_t e;
        if (retire_rd == 5'd0) begin
            fail_run("retire pulse seen for a write to x0");
        end else if (exp_q[retire_id].size() == 0) begin
            fail_run($sformatf("retire on id %0d with no instruction in flight", retire_id));
        end else begin
            e = exp_q[retire_id].pop_front();
            compare_rd(retire_id, retire_rd, e.rd);
            compare_data(retire_id, retire_data, e.data);
            if (e.seq != retire_seq[e.rd]) begin
                fail_run($sformatf("mismatch at %0t: x%0d write %0d retired, expected write %0d",
                                   $time, e.rd, e.seq, retire_seq[e.rd]));
            end
            retire_seq[e.rd]++;
            retired++;
        end
    endtask

    function automatic bit queues_empty();
        bit empty;
        empty = 1'b1;
        for (int i = 0; i < `CORE_ID_COUNT; i++) begin
            if (exp_q[i].size() != 0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    ////////////////////
    // Timeout
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            fail_run($sformatf("timeout after %0d cycles, the stream did not complete", cycles));
        end
    end

    ////////////////////
    // Stimulus and checking
    initial begin
        logic drive_valid;
        void'($urandom(32'hb721));
        instr_valid      = 1'b0;
        instr            = '0;
        model_id         = '0;
        accepted         = 0;
        expected_retires = 0;
        retired          = 0;
        for (int i = 0; i < 32; i++) begin
            arch[i]       = '0;
            issue_seq[i]  = 0;
            retire_seq[i] = 0;
        end
        pick_instr();

        wait (rst_n == 1'b1);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= encode(cur_kind, cur_rd, cur_rs1, cur_rs2, cur_imm);

        // Inputs settle mid cycle, so sample on the falling edge
        while (accepted < NUM_INSTR) begin
            @(negedge clk);
            if (retire_valid) begin
                check_retire();
            end
            if (instr_valid && !stall) begin
                accept_current();
                pick_instr();
                // Occasional one cycle bubble
                drive_valid = (accepted < NUM_INSTR) && ($urandom_range(7, 0) != 0);
            end else begin
                // Bubble over or stalled, same word stays at the input
                drive_valid = 1'b1;
            end
            @(posedge clk);
            instr_valid <= drive_valid;
            instr       <= encode(cur_kind, cur_rd, cur_rs1, cur_rs2, cur_imm);
        end

        // Drain outstanding results
        while (retired < expected_retires) begin
            @(negedge clk);
            if (retire_valid) begin
                check_retire();
            end
        end

        // A trailing x0 multiply still has to leave the pipeline
        repeat (SETTLE_CYCLES) begin
            @(negedge clk);
            if (retire_valid) begin
                check_retire();
            end
        end

        // Idle pipeline takes x0 writes back to back
        // Stuck in-use marks or ids would raise stall here
        repeat (DRAIN_CYCLES) begin
            cur_kind = K_XOR;
            cur_rd   = 5'd0;
            cur_rs1  = 5'($urandom_range(7, 0));
            cur_rs2  = 5'($urandom_range(7, 0));
            cur_imm  = '0;
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= encode(cur_kind, cur_rd, cur_rs1, cur_rs2, cur_imm);
            @(negedge clk);
            if (retire_valid) begin
                check_retire();
            end
            if (stall) begin
                fail_run("stall stayed high after the instruction stream ended");
            end
            accept_current();
        end
        @(posedge clk);
        instr_valid <= 1'b0;

        // Last x0 writes pass writeback without a retire pulse
        repeat (SETTLE_CYCLES) begin
            @(negedge clk);
            if (retire_valid) begin
                check_retire();
            end
        end

        if (retired == expected_retires && queues_empty()) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            fail_run($sformatf("mismatch at %0t: %0d retires seen, %0d expected",
                               $time, retired, expected_retires));
        end
    end

endmodule

// File: include/core_consts.svh
////////////////////
// Core constants
// Data width, id pool size and multiplier depth
////////////////////
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Data word width
`define CORE_XLEN 32

// In-flight instruction ids and id width
`define CORE_ID_COUNT 4
`define CORE_ID_W 2

// Multiplier pipeline depth, issue cycle included
`define CORE_MUL_STAGES 3

`endif

// File: list.f
+incdir+include
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/regfile_ifc.sv
logic/decode_issue.sv
logic/register_file.sv
logic/execute_units.sv
logic/writeback.sv
logic/operand_core.sv
bench/clock_gen.sv
bench/operand_core_tb.sv

// File: logic/decode_issue.sv
////////////////////
// Decode and issue
// Decodes the word, hands out ids, stalls
// on hazards and registers the issue packet
////////////////////
`timescale 1ns/10ps
`include "core_consts.svh"

module decode_issue (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid,
    input  isa_pkg::instr_u    instr,
    output logic               stall,
    rf_decode_if.stage         rf,
    input  logic               alu_blocked,
    input  logic               free_valid,
    input  pipe_pkg::id_t      free_id,
    output logic               iss_valid,
    output pipe_pkg::issue_t   iss
);

    logic                      is_reg;
    logic                      is_imm;
    isa_pkg::op_e              op;
    logic [`CORE_XLEN-1:0]     imm_ext;
    logic                      rd_nzero;
    logic [`CORE_ID_COUNT-1:0] busy;
    pipe_pkg::id_t             next_id;
    logic                      id_avail;
    logic                      waw_hold;
    logic                      mul_prev;
    logic [4:0]                mul_prev_rd;
    logic                      accept;

    ////////////////////
    // Decode
    assign is_reg   = instr.r.opcode == isa_pkg::OPC_REG;
    assign is_imm   = instr.r.opcode == isa_pkg::OPC_IMM;
    assign imm_ext  = {{(`CORE_XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
    assign rd_nzero = instr.r.rd != 5'd0;

    always_comb begin
        op = isa_pkg::OP_ADD;
        if (instr.r.funct3 == isa_pkg::F3_XOR) begin
            op = isa_pkg::OP_XOR;
        end else if (is_reg && instr.r.funct7 == isa_pkg::F7_SUB) begin
            op = isa_pkg::OP_SUB;
        end else if (is_reg && instr.r.funct7 == isa_pkg::F7_MULDIV) begin
            op = isa_pkg::OP_MUL;
        end
    end

    // Immediate ops only read rs1
    assign rf.rs1_addr = instr.r.rs1;
    assign rf.rs2_addr = instr.r.rs2;
    assign rf.uses_rs1 = is_reg | is_imm;
    assign rf.uses_rs2 = is_reg;

    ////////////////////
    // Stall and accept
    // Id freed this cycle can be handed out again at once
    assign id_avail = ~busy[next_id] | (free_valid & (free_id == next_id));

    // ALU op right behind a MUL to the same rd would retire first
    assign waw_hold = mul_prev & (mul_prev_rd == instr.r.rd) & rd_nzero;

    assign stall = instr_valid & (rf.rs1_conflict | rf.rs2_conflict | ~id_avail
                 | ((op != isa_pkg::OP_MUL) & (alu_blocked | waw_hold)));
    assign accept = instr_valid & ~stall;

    // x0 is never marked in use
    assign rf.issue    = accept & rd_nzero;
    assign rf.issue_rd = instr.r.rd;
    assign rf.issue_id = next_id;

    ////////////////////
    // Id allocation, round robin
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy        <= '0;
            next_id     <= '0;
            iss_valid   <= 1'b0;
            mul_prev    <= 1'b0;
            mul_prev_rd <= '0;
        end else begin
            // Release first so a same-cycle allocation keeps the id busy
            if (free_valid) begin
                busy[free_id] <= 1'b0;
            end
            if (accept) begin
                busy[next_id] <= 1'b1;
                next_id       <= next_id + 1'b1;
            end
            iss_valid   <= accept;
            mul_prev    <= accept & (op == isa_pkg::OP_MUL);
            mul_prev_rd <= instr.r.rd;
        end
    end

    // Issue packet payload
    always_ff @(posedge clk) begin
        if (accept) begin
            iss.op       <= op;
            iss.id       <= next_id;
            iss.rd       <= instr.r.rd;
            iss.rd_nzero <= rd_nzero;
            iss.a        <= rf.rs1_data;
            iss.b        <= is_reg ? rf.rs2_data : imm_ext;
        end
    end

    // Writeback only frees ids still out, else a live id could be reissued
    a_free_busy : assert property (@(posedge clk) disable iff (!rst_n)
        free_valid |-> busy[free_id])
        else $error("id released while not in flight");

endmodule

// File: logic/execute_units.sv
////////////////////
// Execute units
// Single-cycle ALU and pipelined multiplier
// merged onto one result port
////////////////////
`timescale 1ns/10ps
`include "core_consts.svh"

module execute_units (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              iss_valid,
    input  pipe_pkg::issue_t  iss,
    output logic              alu_blocked,
    output logic              res_valid,
    output pipe_pkg::result_t res
);

    // First multiplier stage runs on the issue register itself
    localparam int MUL_REGS = `CORE_MUL_STAGES - 1;

    logic                  alu_valid;
    pipe_pkg::result_t     alu_res;
    logic [`CORE_XLEN-1:0] mul_prod;
    logic [MUL_REGS-1:0]   mul_vld;
    pipe_pkg::result_t     mul_res [MUL_REGS];

    ////////////////////
    // ALU, straight off the issue register
    assign alu_valid = iss_valid & (iss.op != isa_pkg::OP_MUL);

    always_comb begin
        alu_res.id       = iss.id;
        alu_res.rd       = iss.rd;
        alu_res.rd_nzero = iss.rd_nzero;
        case (iss.op)
            isa_pkg::OP_SUB: alu_res.data = iss.a - iss.b;
            isa_pkg::OP_XOR: alu_res.data = iss.a ^ iss.b;
            default:         alu_res.data = iss.a + iss.b;
        endcase
    end

    ////////////////////
    // Multiplier
    // Low half of the product only
    assign mul_prod = iss.a * iss.b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_vld <= '0;
        end else begin
            mul_vld <= {mul_vld[MUL_REGS-2:0], iss_valid & (iss.op == isa_pkg::OP_MUL)};
        end
    end

    // Stage payloads, several multiplies can be in flight
    always_ff @(posedge clk) begin
        mul_res[0].id       <= iss.id;
        mul_res[0].rd       <= iss.rd;
        mul_res[0].rd_nzero <= iss.rd_nzero;
        mul_res[0].data     <= mul_prod;
        for (int k = 1; k < MUL_REGS; k++) begin
            mul_res[k] <= mul_res[k-1];
        end
    end

    // Last stage outputs next cycle, keep the ALU off the port
    assign alu_blocked = mul_vld[MUL_REGS-2];

    ////////////////////
    // Result merge
    assign res_valid = alu_valid | mul_vld[MUL_REGS-1];
    assign res       = mul_vld[MUL_REGS-1] ? mul_res[MUL_REGS-1] : alu_res;

    // Decode holds ALU ops back two cycles ahead of this
    a_one_result : assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_valid && mul_vld[MUL_REGS-1]))
        else $error("ALU and multiplier completed together");

endmodule

// File: logic/isa_pkg.sv
////////////////////
// ISA definitions
// Instruction formats, opcodes and operations
////////////////////
package isa_pkg;

    // Register-register format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // Register-immediate format
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // One word, two views; opcode picks the valid one
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;

    // Function fields
    localparam logic [2:0] F3_ADD    = 3'b000;
    localparam logic [2:0] F3_XOR    = 3'b100;
    localparam logic [6:0] F7_SUB    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_MUL
    } op_e;

endpackage

// File: logic/operand_core.sv
////////////////////
// Operand core top
// Decode, register file, execute and writeback
////////////////////
`timescale 1ns/10ps
`include "core_consts.svh"

module operand_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid,
    input  logic [31:0]           instr,
    output logic                  stall,
    output logic                  retire_valid,
    output logic [4:0]            retire_rd,
    output logic [`CORE_ID_W-1:0] retire_id,
    output logic [`CORE_XLEN-1:0] retire_data
);

    rf_decode_if dec_if ();
    rf_wb_if     wb_if ();

    logic              alu_blocked;
    logic              free_valid;
    pipe_pkg::id_t     free_id;
    logic              iss_valid;
    pipe_pkg::issue_t  iss;
    logic              res_valid;
    pipe_pkg::result_t res;

    decode_issue u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (isa_pkg::instr_u'(instr)),
        .stall       (stall),
        .rf          (dec_if),
        .alu_blocked (alu_blocked),
        .free_valid  (free_valid),
        .free_id     (free_id),
        .iss_valid   (iss_valid),
        .iss         (iss)
    );

    register_file u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .dec   (dec_if),
        .wb    (wb_if)
    );

    execute_units u_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .iss_valid   (iss_valid),
        .iss         (iss),
        .alu_blocked (alu_blocked),
        .res_valid   (res_valid),
        .res         (res)
    );

    writeback u_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .res_valid    (res_valid),
        .res          (res),
        .rf           (wb_if),
        .free_valid   (free_valid),
        .free_id      (free_id),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_id    (retire_id),
        .retire_data  (retire_data)
    );

endmodule

// File: logic/pipe_pkg.sv
////////////////////
// Pipeline types
// Ids, issue packets and results
////////////////////
`include "core_consts.svh"

package pipe_pkg;

    typedef logic [`CORE_ID_W-1:0] id_t;

    // Issued operation, operands already resolved
    typedef struct packed {
        isa_pkg::op_e           op;
        id_t                    id;
        logic [4:0]             rd;
        logic                   rd_nzero;
        logic [`CORE_XLEN-1:0]  a;
        logic [`CORE_XLEN-1:0]  b;
    } issue_t;

    // Completed result
    typedef struct packed {
        id_t                    id;
        logic [4:0]             rd;
        logic                   rd_nzero;
        logic [`CORE_XLEN-1:0]  data;
    } result_t;

endpackage

// File: logic/regfile_ifc.sv
////////////////////
// Register file interfaces
// Decode side and writeback side links
////////////////////
`timescale 1ns/10ps
`include "core_consts.svh"

// Decode to register file: source reads and rd reservation
interface rf_decode_if;
    logic [4:0]            rs1_addr;
    logic [4:0]            rs2_addr;
    logic                  uses_rs1;
    logic                  uses_rs2;
    logic                  issue;
    logic [4:0]            issue_rd;
    pipe_pkg::id_t         issue_id;
    logic [`CORE_XLEN-1:0] rs1_data;
    logic [`CORE_XLEN-1:0] rs2_data;
    logic                  rs1_conflict;
    logic                  rs2_conflict;

    modport stage (
        output rs1_addr, rs2_addr, uses_rs1, uses_rs2, issue, issue_rd, issue_id,
        input  rs1_data, rs2_data, rs1_conflict, rs2_conflict
    );
    modport regs (
        input  rs1_addr, rs2_addr, uses_rs1, uses_rs2, issue, issue_rd, issue_id,
        output rs1_data, rs2_data, rs1_conflict, rs2_conflict
    );
endinterface

// Writeback to register file: commit and forwarding by id
interface rf_wb_if;
    pipe_pkg::id_t         rs1_id;
    pipe_pkg::id_t         rs2_id;
    logic [`CORE_XLEN-1:0] rs1_data;
    logic [`CORE_XLEN-1:0] rs2_data;
    logic                  rs1_valid;
    logic                  rs2_valid;
    logic                  retired;
    logic                  rd_nzero;
    logic [4:0]            rd_addr;
    logic [`CORE_XLEN-1:0] rd_data;
    pipe_pkg::id_t         wb_id;

    modport stage (
        input  rs1_id, rs2_id,
        output rs1_data, rs2_data, rs1_valid, rs2_valid,
        output retired, rd_nzero, rd_addr, rd_data, wb_id
    );
    modport regs (
        output rs1_id, rs2_id,
        input  rs1_data, rs2_data, rs1_valid, rs2_valid,
        input  retired, rd_nzero, rd_addr, rd_data, wb_id
    );
endinterface

// File: logic/register_file.sv
////////////////////
// Register file
// 32 registers with producer id tracking,
// forwarding select and conflict detection
////////////////////
`timescale 1ns/10ps
`include "core_consts.svh"

module register_file (
    input  logic       clk,
    input  logic       rst_n,
    rf_decode_if.regs  dec,
    rf_wb_if.regs      wb
);

    logic [`CORE_XLEN-1:0] regs [32];
    logic [31:0]           in_use;
    pipe_pkg::id_t         in_use_id [32];

    logic                  wr_en;
    logic                  clr_en;
    logic                  rs1_in_use;
    logic                  rs2_in_use;

    // Writeback only commits nonzero rd
    assign wr_en  = wb.retired & wb.rd_nzero;
    // Only the latest producer may clear the mark
    assign clr_en = wr_en & (in_use_id[wb.rd_addr] == wb.wb_id);

    ////////////////////
    // Storage and in-use table
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i]      <= '0;
                in_use_id[i] <= '0;
            end
            in_use <= '0;
        end else begin
            if (wr_en) begin
                regs[wb.rd_addr] <= wb.rd_data;
            end
            if (clr_en) begin
                in_use[wb.rd_addr] <= 1'b0;
            end
            // Issue comes last so it wins on a shared rd
            if (dec.issue) begin
                in_use[dec.issue_rd]    <= 1'b1;
                in_use_id[dec.issue_rd] <= dec.issue_id;
            end
        end
    end

    ////////////////////
    // Source read
    // Producer ids go to writeback for matching
    assign wb.rs1_id = in_use_id[dec.rs1_addr];
    assign wb.rs2_id = in_use_id[dec.rs2_addr];

    assign rs1_in_use = in_use[dec.rs1_addr];
    assign rs2_in_use = in_use[dec.rs2_addr];

    // In flight sources take the writeback value
    assign dec.rs1_data = rs1_in_use ? wb.rs1_data : regs[dec.rs1_addr];
    assign dec.rs2_data = rs2_in_use ? wb.rs2_data : regs[dec.rs2_addr];

    // Conflict when the producer is not at writeback yet
    assign dec.rs1_conflict = dec.uses_rs1 & rs1_in_use & ~wb.rs1_valid;
    assign dec.rs2_conflict = dec.uses_rs2 & rs2_in_use & ~wb.rs2_valid;

    ////////////////////
    // Checks
    a_no_issue_x0 : assert property (@(posedge clk) disable iff (!rst_n)
        !(dec.issue && dec.issue_rd == 5'd0))
        else $error("x0 marked in use");

    a_no_retire_x0 : assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> wb.rd_addr != 5'd0)
        else $error("retire committed to x0");

endmodule

// File: logic/writeback.sv
////////////////////
// Writeback
// Commits one result per cycle, forwards it
// by id and releases the id
////////////////////
`timescale 1ns/10ps
`include "core_consts.svh"

module writeback (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  res_valid,
    input  pipe_pkg::result_t     res,
    rf_wb_if.stage                rf,
    output logic                  free_valid,
    output pipe_pkg::id_t         free_id,
    output logic                  retire_valid,
    output logic [4:0]            retire_rd,
    output pipe_pkg::id_t         retire_id,
    output logic [`CORE_XLEN-1:0] retire_data
);

    logic              wb_valid;
    pipe_pkg::result_t wb_res;

    ////////////////////
    // Result register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            wb_res <= res;
        end
    end

    ////////////////////
    // Commit to register file
    assign rf.retired  = wb_valid;
    assign rf.rd_nzero = wb_res.rd_nzero;
    assign rf.rd_addr  = wb_res.rd;
    assign rf.rd_data  = wb_res.data;
    assign rf.wb_id    = wb_res.id;

    // Forward hit when the held id is the asked producer
    assign rf.rs1_valid = wb_valid & (rf.rs1_id == wb_res.id);
    assign rf.rs2_valid = wb_valid & (rf.rs2_id == wb_res.id);
    assign rf.rs1_data  = wb_res.data;
    assign rf.rs2_data  = wb_res.data;

    // Every result frees its id, x0 targets too
    assign free_valid = wb_valid;
    assign free_id    = wb_res.id;

    // Retire port silent for x0
    assign retire_valid = wb_valid & wb_res.rd_nzero;
    assign retire_rd    = wb_res.rd;
    assign retire_id    = wb_res.id;
    assign retire_data  = wb_res.data;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the operand core testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module operand_core_tb -o operand_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/operand_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0
